// File: verilog/sdram_settings.svh
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// user side widths
`define SDRAM_DATA_W            32
`define SDRAM_ADDR_W            25

// user address split, row | bank | column from msb down
`define SDRAM_ROW_W             12
`define SDRAM_BANK_W            2
`define SDRAM_COL_W             11

// device address pins
`define SDRAM_PIN_A_W           16
`define SDRAM_ALL_BANKS_BIT     13

// delay counter loads, the wait lasts load + 1 cycles
`define SDRAM_T_ACT             2
`define SDRAM_T_PRE             2
`define SDRAM_T_CASL            2
`define SDRAM_T_REF             6

`define SDRAM_REFRESH_INTERVAL  750

`endif

// File: verilog/sdram_pkg.sv
package sdram_pkg;

    // cs, ras, cas, we from msb down
    typedef enum logic [3:0] {
        CMD_UNSELECTED = 4'b1000,
        CMD_NOP        = 4'b0111,
        CMD_ACTIVE     = 4'b0011,
        CMD_READ       = 4'b0101,
        CMD_WRITE      = 4'b0100,
        CMD_PRECHARGE  = 4'b0010,
        CMD_REFRESH    = 4'b0001
    } sdram_cmd_e;

    // pin view of the same four bits
    typedef struct packed {
        logic cs;
        logic ras;
        logic cas;
        logic we;
    } sdram_pins_t;

    // written as a code, driven out as pins
    typedef union packed {
        sdram_cmd_e  code;
        sdram_pins_t pins;
    } sdram_cmd_u;

endpackage

// File: verilog/sdram_ifs.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

// queued user request, handed to the command FSM
interface req_if;
    logic                     pending;
    logic                     rw;
    logic [`SDRAM_ADDR_W-1:0] addr;
    logic [`SDRAM_DATA_W-1:0] data;
    logic                     take;

    modport source (output pending, rw, addr, data, input take);
    modport sink (input pending, rw, addr, data, output take);
endinterface

// open row lookup and update
interface row_track_if;
    logic [`SDRAM_BANK_W-1:0] bank;
    logic [`SDRAM_ROW_W-1:0]  row;
    logic                     open_row;
    logic                     close_bank;
    logic                     close_all;
    logic                     bank_open;
    logic                     row_hit;

    modport tracker (
        input  bank, row, open_row, close_bank, close_all,
        output bank_open, row_hit
    );
    modport ctrl (
        output bank, row, open_row, close_bank, close_all,
        input  bank_open, row_hit
    );
endinterface

// File: verilog/request_queue.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module request_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic                     rw,
    input  logic [`SDRAM_ADDR_W-1:0] user_addr,
    input  logic [`SDRAM_DATA_W-1:0] data_in,
    output logic                     busy,
    req_if.source                    req
);

    logic pending_q;
    logic busy_q;
    logic accept;
    logic pending_d;

    // new requests only when the slot is empty
    assign accept = in_valid && !busy_q;

    always_comb begin
        pending_d = pending_q;
        if (accept) begin
            pending_d = 1'b1;
        end else if (req.take) begin
            pending_d = 1'b0;
        end
    end

    // busy held high through reset, slot starts empty
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
            busy_q    <= 1'b1;
        end else begin
            pending_q <= pending_d;
            busy_q    <= pending_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.rw   <= rw;
            req.addr <= user_addr;
            req.data <= data_in;
        end
    end

    assign req.pending = pending_q;
    assign busy        = busy_q;

endmodule

// File: verilog/refresh_timer.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic refresh_ack,
    output logic refresh_pending
);

    localparam int CNT_W = $clog2(`SDRAM_REFRESH_INTERVAL + 1);

    logic [CNT_W-1:0] count_q;
    logic             flag_q;
    logic             wrap;

    assign wrap = (count_q == CNT_W'(`SDRAM_REFRESH_INTERVAL));

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
            flag_q  <= 1'b0;
        end else begin
            count_q <= wrap ? '0 : count_q + 1'b1;
            // a fresh interval wins over a late ack
            if (wrap) begin
                flag_q <= 1'b1;
            end else if (refresh_ack) begin
                flag_q <= 1'b0;
            end
        end
    end

    assign refresh_pending = flag_q;

endmodule

// File: verilog/bank_row_tracker.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module bank_row_tracker (
    input  logic          clk,
    input  logic          rst,
    row_track_if.tracker  rt
);

    localparam int NUM_BANKS = 1 << `SDRAM_BANK_W;

    logic [NUM_BANKS-1:0]    open_q;
    logic [`SDRAM_ROW_W-1:0] row_q [NUM_BANKS];

    // open bits, precharge beats activate
    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else if (rt.close_all) begin
            open_q <= '0;
        end else if (rt.close_bank) begin
            open_q[rt.bank] <= 1'b0;
        end else if (rt.open_row) begin
            open_q[rt.bank] <= 1'b1;
        end
    end

    // row address only matters while the bank is open
    always_ff @(posedge clk) begin
        if (rt.open_row) begin
            row_q[rt.bank] <= rt.row;
        end
    end

    assign rt.bank_open = open_q[rt.bank];
    assign rt.row_hit   = open_q[rt.bank] && (row_q[rt.bank] == rt.row);

endmodule

// File: verilog/sdram_cmd_fsm.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module sdram_cmd_fsm
    import sdram_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      refresh_pending,
    output logic                      refresh_ack,
    req_if.sink                       req,
    row_track_if.ctrl                 rt,
    output logic                      out_valid,
    output logic [`SDRAM_DATA_W-1:0]  data_out,
    output logic                      sdram_cle,
    output logic                      sdram_cs,
    output logic                      sdram_ras,
    output logic                      sdram_cas,
    output logic                      sdram_we,
    output logic [`SDRAM_BANK_W-1:0]  sdram_ba,
    output logic [`SDRAM_PIN_A_W-1:0] sdram_a,
    output logic [`SDRAM_DATA_W-1:0]  sdram_dqo,
    output logic                      sdram_dq_oe,
    input  logic [`SDRAM_DATA_W-1:0]  sdram_dqi
);

    localparam logic [2:0] IDLE = 3'd0, ACTIVATE = 3'd1, READ = 3'd2, READ_RES = 3'd3;
    localparam logic [2:0] WRITE = 3'd4, PRECHARGE = 3'd5, REFRESH = 3'd6, WAIT = 3'd7;
    localparam int DLY_W = 4;
    localparam int COL_LO = `SDRAM_COL_W;
    localparam int ROW_LO = `SDRAM_COL_W + `SDRAM_BANK_W;
    // idle gap after read data before the next request, 11 cycles
    localparam logic [DLY_W-1:0] READ_HOLD = DLY_W'(10);

    logic [2:0]                state_q, state_d, next_q, next_d;
    logic [DLY_W-1:0]          delay_q, delay_d;
    logic                      pre_all_q, pre_all_d;
    logic                      rw_q, cle_q, oe_q, out_valid_q;
    logic [`SDRAM_ADDR_W-1:0]  addr_q, key_addr;
    logic [`SDRAM_DATA_W-1:0]  wr_data_q, dq_q, dqi_q, rd_data_q;
    logic [`SDRAM_BANK_W-1:0]  ba_q, ba_d;
    logic [`SDRAM_PIN_A_W-1:0] a_q, a_d;
    sdram_cmd_u                sdram_cmd, cmd_d;

    // lookup key follows the queue in IDLE, the latched request otherwise
    assign key_addr   = (state_q == IDLE) ? req.addr : addr_q;
    assign rt.bank    = key_addr[COL_LO +: `SDRAM_BANK_W];
    assign rt.row     = key_addr[ROW_LO +: `SDRAM_ROW_W];
    assign rt.open_row   = (state_q == ACTIVATE);
    assign rt.close_bank = (state_q == PRECHARGE) && !pre_all_q;
    assign rt.close_all  = (state_q == PRECHARGE) && pre_all_q;

    assign refresh_ack = (state_q == IDLE) && refresh_pending;
    assign req.take    = (state_q == IDLE) && !refresh_pending && req.pending;

    always_comb begin
        state_d    = state_q;
        next_d     = next_q;
        delay_d    = delay_q;
        pre_all_d  = pre_all_q;
        cmd_d.code = CMD_NOP;
        ba_d       = addr_q[COL_LO +: `SDRAM_BANK_W];
        a_d        = '0;
        case (state_q)
            IDLE: begin
                if (refresh_pending) begin
                    state_d   = PRECHARGE;
                    next_d    = REFRESH;
                    pre_all_d = 1'b1;
                end else if (req.pending) begin
                    pre_all_d = 1'b0;
                    if (rt.row_hit) begin
                        state_d = req.rw ? WRITE : READ;
                    end else if (rt.bank_open) begin
                        // another row open in this bank
                        state_d = PRECHARGE;
                        next_d  = ACTIVATE;
                    end else begin
                        state_d = ACTIVATE;
                    end
                end
            end
            ACTIVATE: begin
                cmd_d.code = CMD_ACTIVE;
                a_d        = `SDRAM_PIN_A_W'(addr_q[ROW_LO +: `SDRAM_ROW_W]);
                delay_d    = DLY_W'(`SDRAM_T_ACT);
                next_d     = rw_q ? WRITE : READ;
                state_d    = WAIT;
            end
            READ: begin
                cmd_d.code = CMD_READ;
                a_d        = `SDRAM_PIN_A_W'({addr_q[`SDRAM_COL_W-1:0], 2'b00});
                delay_d    = DLY_W'(`SDRAM_T_CASL);
                next_d     = READ_RES;
                state_d    = WAIT;
            end
            READ_RES: begin
                delay_d = READ_HOLD;
                next_d  = IDLE;
                state_d = WAIT;
            end
            WRITE: begin
                cmd_d.code = CMD_WRITE;
                a_d        = `SDRAM_PIN_A_W'({addr_q[`SDRAM_COL_W-1:0], 2'b00});
                state_d    = IDLE;
            end
            PRECHARGE: begin
                cmd_d.code = CMD_PRECHARGE;
                a_d[`SDRAM_ALL_BANKS_BIT] = pre_all_q;
                delay_d    = DLY_W'(`SDRAM_T_PRE);
                state_d    = WAIT;
            end
            REFRESH: begin
                cmd_d.code = CMD_REFRESH;
                delay_d    = DLY_W'(`SDRAM_T_REF);
                next_d     = IDLE;
                state_d    = WAIT;
            end
            default: begin
                if (delay_q == '0) begin
                    state_d = next_q;
                end else begin
                    delay_d = delay_q - 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q        <= IDLE;
            next_q         <= IDLE;
            delay_q        <= '0;
            pre_all_q      <= 1'b0;
            sdram_cmd.code <= CMD_NOP;
            cle_q          <= 1'b0;
            oe_q           <= 1'b0;
            out_valid_q    <= 1'b0;
        end else begin
            state_q     <= state_d;
            next_q      <= next_d;
            delay_q     <= delay_d;
            pre_all_q   <= pre_all_d;
            sdram_cmd   <= cmd_d;
            cle_q       <= 1'b1;
            oe_q        <= (state_q == WRITE);
            out_valid_q <= (state_q == READ_RES);
        end
    end

    always_ff @(posedge clk) begin
        ba_q  <= ba_d;
        a_q   <= a_d;
        dqi_q <= sdram_dqi;
        if (req.take) begin
            rw_q      <= req.rw;
            addr_q    <= req.addr;
            wr_data_q <= req.data;
        end
        if (state_q == WRITE) begin
            dq_q <= wr_data_q;
        end
        if (state_q == READ_RES) begin
            rd_data_q <= dqi_q;
        end
    end

    assign sdram_cle   = cle_q;
    assign sdram_cs    = sdram_cmd.pins.cs;
    assign sdram_ras   = sdram_cmd.pins.ras;
    assign sdram_cas   = sdram_cmd.pins.cas;
    assign sdram_we    = sdram_cmd.pins.we;
    assign sdram_ba    = ba_q;
    assign sdram_a     = a_q;
    assign sdram_dqo   = dq_q;
    assign sdram_dq_oe = oe_q;
    assign out_valid   = out_valid_q;
    assign data_out    = rd_data_q;

endmodule

// File: verilog/sdram_ctrl_top.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module sdram_ctrl_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rw,
    input  logic                      in_valid,
    input  logic [`SDRAM_ADDR_W-1:0]  user_addr,
    input  logic [`SDRAM_DATA_W-1:0]  data_in,
    input  logic [`SDRAM_DATA_W-1:0]  sdram_dqi,
    output logic                      busy,
    output logic                      out_valid,
    output logic [`SDRAM_DATA_W-1:0]  data_out,
    output logic                      sdram_cle,
    output logic                      sdram_cs,
    output logic                      sdram_ras,
    output logic                      sdram_cas,
    output logic                      sdram_we,
    output logic [`SDRAM_BANK_W-1:0]  sdram_ba,
    output logic [`SDRAM_PIN_A_W-1:0] sdram_a,
    output logic [`SDRAM_DATA_W-1:0]  sdram_dqo,
    output logic                      sdram_dq_oe
);

    logic refresh_pending;
    logic refresh_ack;

    req_if       i_req ();
    row_track_if i_row_track ();

    request_queue i_request_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .rw        (rw),
        .user_addr (user_addr),
        .data_in   (data_in),
        .busy      (busy),
        .req       (i_req.source)
    );

    refresh_timer i_refresh_timer (
        .clk             (clk),
        .rst             (rst),
        .refresh_ack     (refresh_ack),
        .refresh_pending (refresh_pending)
    );

    bank_row_tracker i_bank_row_tracker (
        .clk (clk),
        .rst (rst),
        .rt  (i_row_track.tracker)
    );

    sdram_cmd_fsm i_sdram_cmd_fsm (
        .clk             (clk),
        .rst             (rst),
        .refresh_pending (refresh_pending),
        .refresh_ack     (refresh_ack),
        .req             (i_req.sink),
        .rt              (i_row_track.ctrl),
        .out_valid       (out_valid),
        .data_out        (data_out),
        .sdram_cle       (sdram_cle),
        .sdram_cs        (sdram_cs),
        .sdram_ras       (sdram_ras),
        .sdram_cas       (sdram_cas),
        .sdram_we        (sdram_we),
        .sdram_ba        (sdram_ba),
        .sdram_a         (sdram_a),
        .sdram_dqo       (sdram_dqo),
        .sdram_dq_oe     (sdram_dq_oe),
        .sdram_dqi       (sdram_dqi)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

// File: testbench/sdram_ctrl_chk.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module sdram_ctrl_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      sdram_cs,
    input logic                      sdram_ras,
    input logic                      sdram_cas,
    input logic                      sdram_we,
    input logic [`SDRAM_PIN_A_W-1:0] sdram_a,
    input logic                      out_valid
);

    logic [3:0] cmd;
    logic       is_act;
    logic       is_rw;
    logic       is_pre_all;
    logic       is_ref;
    logic       pre_all_seen;

    // cs ras cas we
    assign cmd        = {sdram_cs, sdram_ras, sdram_cas, sdram_we};
    assign is_act     = (cmd == 4'b0011);
    assign is_rw      = (cmd == 4'b0101) || (cmd == 4'b0100);
    assign is_pre_all = (cmd == 4'b0010) && sdram_a[`SDRAM_ALL_BANKS_BIT];
    assign is_ref     = (cmd == 4'b0001);

    // last command other than NOP was a precharge of all banks
    always_ff @(posedge clk) begin
        if (rst) begin
            pre_all_seen <= 1'b0;
        end else if (is_pre_all) begin
            pre_all_seen <= 1'b1;
        end else if (cmd != 4'b0111) begin
            pre_all_seen <= 1'b0;
        end
    end

    act_to_rw: assert property (@(posedge clk) disable iff (rst)
        is_rw |-> !$past(is_act, 1) && !$past(is_act, 2) && !$past(is_act, 3))
        else $error("READ or WRITE within 3 cycles of ACTIVE");

    ref_after_pre_all: assert property (@(posedge clk) disable iff (rst)
        is_ref |-> pre_all_seen)
        else $error("REFRESH without a preceding precharge of all banks");

    single_out_valid: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid high for two cycles in a row");

endmodule

// File: testbench/tb_sdram_ctrl.sv
`timescale 1ns/100ps
`include "sdram_settings.svh"

module tb_sdram_ctrl;

    localparam int DATA_W = `SDRAM_DATA_W;
    localparam int ADDR_W = `SDRAM_ADDR_W;
    localparam int ROW_W = `SDRAM_ROW_W;
    localparam int BANK_W = `SDRAM_BANK_W;
    localparam int COL_W = `SDRAM_COL_W;
    localparam int POOL_SIZE = 16;
    localparam int N_RANDOM = 240;
    // request count over all tests including the dropped one
    localparam int N_REQ = 2 + 32 + 16 + 16 + (N_RANDOM + 16) + 4;
    localparam int WATCHDOG_CYCLES = N_REQ * 200 + 2000;
    localparam int REFRESH_GAP_MAX = 800;
    // quiet window after the last read, longer than one full read
    localparam int DRAIN_CYCLES = 32;

    // SDRAM command codes as cs ras cas we
    localparam logic [3:0] C_ACT = 4'b0011;
    localparam logic [3:0] C_READ = 4'b0101;
    localparam logic [3:0] C_WRITE = 4'b0100;
    localparam logic [3:0] C_PRE = 4'b0010;
    localparam logic [3:0] C_REF = 4'b0001;

    logic                          clk;
    logic                          rst;
    logic                          rw;
    logic                          in_valid;
    logic [ADDR_W-1:0]             user_addr;
    logic [DATA_W-1:0]             data_in;
    logic [DATA_W-1:0]             sdram_dqi = '0;
    logic                          busy;
    logic                          out_valid;
    logic [DATA_W-1:0]             data_out;
    logic                          sdram_cle;
    logic                          sdram_cs;
    logic                          sdram_ras;
    logic                          sdram_cas;
    logic                          sdram_we;
    logic [BANK_W-1:0]             sdram_ba;
    logic [`SDRAM_PIN_A_W-1:0]     sdram_a;
    logic [DATA_W-1:0]             sdram_dqo;
    logic                          sdram_dq_oe;

    // user view of memory and the device model contents
    logic [DATA_W-1:0]             shadow [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0]             device_mem [logic [ADDR_W-1:0]];
    logic [ROW_W-1:0]              open_row [4];
    logic [3:0]                    bank_is_open = '0;
    logic [3:0]                    model_cmd;
    logic [ADDR_W-1:0]             model_key;
    logic [DATA_W-1:0]             expected_q [$];
    logic [DATA_W-1:0]             expected;
    logic [ADDR_W-1:0]             pool [POOL_SIZE];
    logic [ADDR_W-1:0]             ghost_addr;
    int                            refresh_count = 0;
    int                            since_refresh = 0;
    int                            refresh_start;
    int                            idx;
    integer                        seed;

    tb_clock #(.PERIOD_NS(20)) i_tb_clock (.clk(clk));

    sdram_ctrl_top i_sdram_ctrl_top (
        .clk         (clk),
        .rst         (rst),
        .rw          (rw),
        .in_valid    (in_valid),
        .user_addr   (user_addr),
        .data_in     (data_in),
        .sdram_dqi   (sdram_dqi),
        .busy        (busy),
        .out_valid   (out_valid),
        .data_out    (data_out),
        .sdram_cle   (sdram_cle),
        .sdram_cs    (sdram_cs),
        .sdram_ras   (sdram_ras),
        .sdram_cas   (sdram_cas),
        .sdram_we    (sdram_we),
        .sdram_ba    (sdram_ba),
        .sdram_a     (sdram_a),
        .sdram_dqo   (sdram_dqo),
        .sdram_dq_oe (sdram_dq_oe)
    );

    bind sdram_cmd_fsm sdram_ctrl_chk i_sdram_ctrl_chk (
        .clk       (clk),
        .rst       (rst),
        .sdram_cs  (sdram_cs),
        .sdram_ras (sdram_ras),
        .sdram_cas (sdram_cas),
        .sdram_we  (sdram_we),
        .sdram_a   (sdram_a),
        .out_valid (out_valid)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] want,
                               input string what);
        if (actual !== want) begin
            abort_run($sformatf("error at %0t ns: %s, got %h, expected %h",
                                $time, what, actual, want));
        end
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input int row, input int bank,
                                                    input int col);
        return {ROW_W'(row), BANK_W'(bank), COL_W'(col)};
    endfunction

    // last word written to the address or zero
    function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end else begin
            return '0;
        end
    endfunction

    // waits for a free slot and offers the request for one cycle
    task automatic issue_request(input logic is_write, input logic [ADDR_W-1:0] addr,
                                 input logic [DATA_W-1:0] data);
        while (busy !== 1'b0) begin
            @(posedge clk);
            #2;
        end
        in_valid  = 1'b1;
        rw        = is_write;
        user_addr = addr;
        data_in   = data;
        if (is_write) begin
            shadow[addr] = data;
        end else begin
            expected_q.push_back(ref_read(addr));
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // device model that also watches the refresh rate
    always begin
        @(posedge clk);
        #2;
        if (rst) begin
            since_refresh = 0;
        end else begin
            since_refresh++;
            if (since_refresh > REFRESH_GAP_MAX) begin
                abort_run($sformatf("no REFRESH command for %0d cycles", since_refresh));
            end
            model_cmd = {sdram_cs, sdram_ras, sdram_cas, sdram_we};
            model_key = {open_row[sdram_ba], sdram_ba, sdram_a[COL_W+1:2]};
            case (model_cmd)
                C_ACT: begin
                    open_row[sdram_ba]     = sdram_a[ROW_W-1:0];
                    bank_is_open[sdram_ba] = 1'b1;
                end
                C_PRE: begin
                    if (sdram_a[`SDRAM_ALL_BANKS_BIT]) begin
                        bank_is_open = '0;
                    end else begin
                        bank_is_open[sdram_ba] = 1'b0;
                    end
                end
                C_WRITE: begin
                    if (!bank_is_open[sdram_ba]) begin
                        abort_run("WRITE command to a bank with no open row");
                    end
                    check_value(sdram_dq_oe, 1, "data output enable during WRITE");
                    device_mem[model_key] = sdram_dqo;
                end
                C_READ: begin
                    if (!bank_is_open[sdram_ba]) begin
                        abort_run("READ command to a bank with no open row");
                    end
                    sdram_dqi = device_mem.exists(model_key) ? device_mem[model_key] : '0;
                end
                C_REF: begin
                    if (bank_is_open != 4'b0000) begin
                        abort_run("REFRESH command while a bank is still open");
                    end
                    refresh_count++;
                    since_refresh = 0;
                end
                default: begin
                end
            endcase
        end
    end

    // read results against the queue of expected words
    always begin
        @(posedge clk);
        #2;
        if (!rst && out_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                abort_run("out_valid pulse with no read outstanding");
            end
            expected = expected_q.pop_front();
            check_value(data_out, expected, "read data");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout, run did not finish within %0d cycles",
                            WATCHDOG_CYCLES));
    end

    initial begin
        seed      = 32'h9886d9cc;
        rst       = 1'b1;
        rw        = 1'b0;
        in_valid  = 1'b0;
        user_addr = '0;
        data_in   = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;

        // state right after reset and one write read back
        check_value(busy, 0, "busy after reset");
        check_value(sdram_cle, 1, "sdram_cle after reset");
        check_value(out_valid, 0, "out_valid after reset");
        issue_request(1'b1, make_addr(1, 0, 4), 32'hcafe_0001);
        issue_request(1'b0, make_addr(1, 0, 4), '0);

        // many columns in one row of one bank
        for (int i = 0; i < 16; i++) begin
            issue_request(1'b1, make_addr(5, 1, 3 * i), $random(seed));
        end
        for (int i = 0; i < 16; i++) begin
            issue_request(1'b0, make_addr(5, 1, 3 * i), '0);
        end

        // two rows fighting over bank 2
        for (int i = 0; i < 8; i++) begin
            issue_request(1'b1, make_addr((i % 2 == 0) ? 3 : 9, 2, i), $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            issue_request(1'b0, make_addr((i % 2 == 0) ? 3 : 9, 2, i), '0);
        end

        // all four banks interleaved
        for (int i = 0; i < 8; i++) begin
            issue_request(1'b1, make_addr(40 + i % 4, i % 4, 8 * i), $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            issue_request(1'b0, make_addr(40 + i % 4, i % 4, 8 * i), '0);
        end

        // long random run across several refresh intervals
        // bit 24 stays clear so the pool never meets the dropped address
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = ADDR_W'($random(seed)) & 25'h0ff_ffff;
        end
        refresh_start = refresh_count;
        for (int i = 0; i < N_RANDOM; i++) begin
            idx = int'($unsigned($random(seed)) % POOL_SIZE);
            issue_request(1'($random(seed)), pool[idx], $random(seed));
        end
        for (int i = 0; i < 16; i++) begin
            issue_request(1'b0, make_addr(5, 1, 3 * i), '0);
        end
        check_value(refresh_count - refresh_start >= 3, 1,
                    "at least 3 REFRESH commands in the long run");

        // request offered while busy must be dropped
        ghost_addr = make_addr(12'hfff, 3, 11'h7ff);
        issue_request(1'b1, make_addr(60, 3, 1), 32'h5a5a_0f0f);
        check_value(busy, 1, "busy right after an accepted request");
        in_valid  = 1'b1;
        rw        = 1'b1;
        user_addr = ghost_addr;
        data_in   = 32'hdead_beef;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        issue_request(1'b0, make_addr(60, 3, 1), '0);
        issue_request(1'b0, ghost_addr, '0);

        while (expected_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
        // any out_valid beyond the accepted reads shows up here
        repeat (DRAIN_CYCLES) @(posedge clk);
        @(negedge clk);
        check_value(device_mem.exists(ghost_addr), 0, "dropped write reached memory");
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/sdram_pkg.sv
verilog/sdram_ifs.sv
verilog/request_queue.sv
verilog/refresh_timer.sv
verilog/bank_row_tracker.sv
verilog/sdram_cmd_fsm.sv
verilog/sdram_ctrl_top.sv
testbench/tb_clock.sv
testbench/sdram_ctrl_chk.sv
testbench/tb_sdram_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# builds the SDRAM controller testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sdram_ctrl \
    -f src.f \
    -o sim_sdram_ctrl

./obj_dir/sim_sdram_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
